//--- rob_pkg.sv
// reorder buffer package with the entry count and every field width of the buffer
package rob_pkg;

	// ------------------------------
	// buffer geometry
	// ------------------------------
	localparam int ROB_DEPTH = 32;              // live entries when full
	localparam int ROB_IDX_W = 5;               // log2 of ROB_DEPTH
	localparam int ROB_PTR_W = ROB_IDX_W + 1;   // index plus wrap bit

	// ------------------------------
	// rename and free list
	// ------------------------------
	localparam int PRF_TAG_W  = 6;              // physical register tag
	localparam int ARCH_REG_W = 5;              // logical register number
	localparam int FL_HEAD_W  = 5;              // free-list head snapshot

	// tag value shown on the retire port while no entry retires
	localparam int NULL_TAG = 31;

	// ------------------------------
	// branch and pc
	// ------------------------------
	localparam int BR_MASK_W  = 4;              // one bit per branch in flight
	localparam int XLEN       = 64;             // pc and target width
	localparam int INSN_BYTES = 4;              // fixed instruction size

endpackage

//--- rob_ctrl.sv
// reorder buffer control with wrap-bit pointers, dispatch/retire handshakes and recovery one-shot
`timescale 1ns/100ps

module rob_ctrl (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          dispatch_valid_i,
	input  logic                          retire_ready_i,
	input  logic                          head_done_i,
	input  logic                          recover_req_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0] resolve_idx_i,
	output logic                          dispatch_ready_o,
	output logic                          dispatch_fire_o,
	output logic                          retire_valid_o,
	output logic                          retire_fire_o,
	output logic                          recover_o,
	output logic [rob_pkg::ROB_IDX_W-1:0] head_idx_o,
	output logic [rob_pkg::ROB_IDX_W-1:0] tail_idx_o,
	output logic [rob_pkg::ROB_PTR_W-1:0] tail_ptr_o
);

	logic [rob_pkg::ROB_PTR_W-1:0] head_ptr_r;
	logic [rob_pkg::ROB_PTR_W-1:0] tail_ptr_r;
	logic [rob_pkg::ROB_PTR_W-1:0] rec_tail_ptr;   // tail after a rollback
	logic [rob_pkg::ROB_PTR_W-1:0] occupancy;      // live entries
	logic                          br_wrap;        // wrap bit of the resolving entry
	logic                          rec_mark_r;     // armed while high
	logic                          full;
	logic                          empty;

	// ------------------------------
	// occupancy
	// ------------------------------
	assign head_idx_o = head_ptr_r[rob_pkg::ROB_IDX_W-1:0];
	assign tail_idx_o = tail_ptr_r[rob_pkg::ROB_IDX_W-1:0];
	assign tail_ptr_o = tail_ptr_r;

	assign empty = (head_ptr_r == tail_ptr_r);
	// same index, opposite lap
	assign full  = (head_idx_o == tail_idx_o) &&
		(head_ptr_r[rob_pkg::ROB_IDX_W] != tail_ptr_r[rob_pkg::ROB_IDX_W]);

	assign occupancy = tail_ptr_r - head_ptr_r;

	// ------------------------------
	// handshakes
	// ------------------------------
	assign recover_o        = recover_req_i & rec_mark_r;
	assign dispatch_ready_o = ~full & ~recover_o;   // tail is busy rolling back
	assign dispatch_fire_o  = dispatch_valid_i & dispatch_ready_o;
	assign retire_valid_o   = ~empty & head_done_i;
	assign retire_fire_o    = retire_valid_o & retire_ready_i;

	// the branch sits between head and tail, so it shares the head's lap
	// unless its index has already wrapped below the head
	assign br_wrap = (resolve_idx_i >= head_idx_o) ? head_ptr_r[rob_pkg::ROB_IDX_W] :
		~head_ptr_r[rob_pkg::ROB_IDX_W];
	assign rec_tail_ptr = {br_wrap, resolve_idx_i} + rob_pkg::ROB_PTR_W'(1);

	always_ff @(posedge clk) begin
		if (rst) begin
			head_ptr_r <= '0;
			tail_ptr_r <= '0;
			rec_mark_r <= 1'b1;
		end else begin
			if (retire_fire_o) begin
				head_ptr_r <= head_ptr_r + rob_pkg::ROB_PTR_W'(1);
			end
			if (recover_o) begin
				tail_ptr_r <= rec_tail_ptr;   // drop everything younger than the branch
			end else if (dispatch_fire_o) begin
				tail_ptr_r <= tail_ptr_r + rob_pkg::ROB_PTR_W'(1);
			end
			rec_mark_r <= ~recover_o;   // disarm for one cycle after a recovery
		end
	end

	// ------------------------------
	// checks
	// ------------------------------
	// an overrun or an underrun of the pointers shows as a count above the depth
	assert property (@(posedge clk) disable iff (rst)
		occupancy <= rob_pkg::ROB_DEPTH);

endmodule

//--- rob_entry_store.sv
// reorder buffer payload storage with a tail write port and head, recovery and npc read ports
`timescale 1ns/100ps

module rob_entry_store (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           dispatch_fire_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  tail_idx_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  head_idx_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  resolve_idx_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  npc_idx_i,
	input  logic [rob_pkg::PRF_TAG_W-1:0]  new_tag_i,
	input  logic [rob_pkg::PRF_TAG_W-1:0]  old_tag_i,
	input  logic [rob_pkg::ARCH_REG_W-1:0] logic_dest_i,
	input  logic [rob_pkg::XLEN-1:0]       pc_i,
	input  logic                           br_flag_i,
	input  logic                           br_pretaken_i,
	input  logic [rob_pkg::XLEN-1:0]       br_target_i,
	input  logic [rob_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic [rob_pkg::FL_HEAD_W-1:0]  fl_head_i,
	input  logic                           store_i,
	input  logic                           halt_i,
	output logic [rob_pkg::PRF_TAG_W-1:0]  head_new_tag_o,
	output logic [rob_pkg::PRF_TAG_W-1:0]  head_old_tag_o,
	output logic [rob_pkg::ARCH_REG_W-1:0] head_logic_dest_o,
	output logic                           head_store_o,
	output logic                           head_halt_o,
	output logic                           res_br_flag_o,
	output logic                           res_pretaken_o,
	output logic [rob_pkg::XLEN-1:0]       res_target_o,
	output logic [rob_pkg::FL_HEAD_W-1:0]  res_fl_head_o,
	output logic [rob_pkg::BR_MASK_W-1:0]  res_br_mask_o,
	output logic [rob_pkg::XLEN-1:0]       npc_o
);

	// ------------------------------
	// entry arrays
	// ------------------------------
	logic [rob_pkg::PRF_TAG_W-1:0]  new_tag_r    [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::PRF_TAG_W-1:0]  old_tag_r    [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::ARCH_REG_W-1:0] logic_dest_r [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::XLEN-1:0]       pc_r         [rob_pkg::ROB_DEPTH];
	logic                           br_flag_r    [rob_pkg::ROB_DEPTH];
	logic                           pretaken_r   [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::XLEN-1:0]       target_r     [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::BR_MASK_W-1:0]  br_mask_r    [rob_pkg::ROB_DEPTH];
	logic [rob_pkg::FL_HEAD_W-1:0]  fl_head_r    [rob_pkg::ROB_DEPTH];
	logic                           store_r      [rob_pkg::ROB_DEPTH];
	logic                           halt_r       [rob_pkg::ROB_DEPTH];

	// rename fields come up holding the null tag
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < rob_pkg::ROB_DEPTH; i++) begin
				new_tag_r[i]    <= rob_pkg::PRF_TAG_W'(rob_pkg::NULL_TAG);
				old_tag_r[i]    <= rob_pkg::PRF_TAG_W'(rob_pkg::NULL_TAG);
				logic_dest_r[i] <= rob_pkg::ARCH_REG_W'(rob_pkg::NULL_TAG);
			end
		end else if (dispatch_fire_i) begin
			new_tag_r[tail_idx_i]    <= new_tag_i;      // from the free list
			old_tag_r[tail_idx_i]    <= old_tag_i;      // from the map table
			logic_dest_r[tail_idx_i] <= logic_dest_i;
		end
	end

	// remaining payload, written only on a dispatch
	always_ff @(posedge clk) begin
		if (dispatch_fire_i) begin
			pc_r[tail_idx_i]       <= pc_i;
			br_flag_r[tail_idx_i]  <= br_flag_i;
			pretaken_r[tail_idx_i] <= br_pretaken_i;
			target_r[tail_idx_i]   <= br_target_i;
			br_mask_r[tail_idx_i]  <= br_mask_i;
			fl_head_r[tail_idx_i]  <= fl_head_i;   // snapshot for rollback
			store_r[tail_idx_i]    <= store_i;
			halt_r[tail_idx_i]     <= halt_i;
		end
	end

	// ------------------------------
	// read ports
	// ------------------------------
	// retire side
	assign head_new_tag_o    = new_tag_r[head_idx_i];
	assign head_old_tag_o    = old_tag_r[head_idx_i];
	assign head_logic_dest_o = logic_dest_r[head_idx_i];
	assign head_store_o      = store_r[head_idx_i];
	assign head_halt_o       = halt_r[head_idx_i];

	// branch resolution side
	assign res_br_flag_o  = br_flag_r[resolve_idx_i];
	assign res_pretaken_o = pretaken_r[resolve_idx_i];
	assign res_target_o   = target_r[resolve_idx_i];
	assign res_fl_head_o  = fl_head_r[resolve_idx_i];
	assign res_br_mask_o  = br_mask_r[resolve_idx_i];

	// fall-through pc for the branch unit
	assign npc_o = pc_r[npc_idx_i] + rob_pkg::XLEN'(rob_pkg::INSN_BYTES);

endmodule

//--- rob_done_tracker.sv
// reorder buffer done bits, cleared at dispatch and set by functional-unit completion
`timescale 1ns/100ps

module rob_done_tracker (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          dispatch_fire_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0] tail_idx_i,
	input  logic                          complete_valid_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0] complete_idx_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0] head_idx_i,
	output logic                          head_done_o
);

	logic [rob_pkg::ROB_DEPTH-1:0] done_r;   // one bit per entry

	always_ff @(posedge clk) begin
		if (rst) begin
			done_r <= '0;
		end else begin
			if (dispatch_fire_i) begin
				done_r[tail_idx_i] <= 1'b0;   // new entry starts pending
			end
			if (complete_valid_i) begin
				done_r[complete_idx_i] <= 1'b1;
			end
		end
	end

	assign head_done_o = done_r[head_idx_i];

	// an entry cannot finish in the cycle it is handed out
	assert property (@(posedge clk) disable iff (rst)
		dispatch_fire_i && complete_valid_i |-> complete_idx_i != tail_idx_i);

endmodule

//--- rob_branch_check.sv
// branch resolution check of direction and target against the stored prediction
`timescale 1ns/100ps

module rob_branch_check (
	input  logic                     resolve_valid_i,
	input  logic                     resolve_taken_i,
	input  logic [rob_pkg::XLEN-1:0] resolve_target_i,
	input  logic                     br_flag_i,
	input  logic                     pretaken_i,
	input  logic [rob_pkg::XLEN-1:0] target_i,
	output logic                     mispredict_o,
	output logic                     br_right_o
);

	logic dir_wrong;
	logic tgt_wrong;

	assign dir_wrong = (pretaken_i != resolve_taken_i);
	assign tgt_wrong = (target_i != resolve_target_i);   // full target compare

	always_comb begin
		mispredict_o = 1'b0;
		br_right_o   = 1'b0;
		// non-branch entries are ignored
		if (resolve_valid_i && br_flag_i) begin
			if (dir_wrong || tgt_wrong) begin
				mispredict_o = 1'b1;
			end else begin
				br_right_o = 1'b1;
			end
		end
	end

endmodule

//--- rob_top.sv
// reorder buffer top joining control, payload store, done tracking and branch check
`timescale 1ns/100ps

module rob_top (
	input  logic                           clk,
	input  logic                           rst,
	// dispatch
	input  logic                           dispatch_valid_i,
	output logic                           dispatch_ready_o,
	input  logic [rob_pkg::PRF_TAG_W-1:0]  new_tag_i,
	input  logic [rob_pkg::PRF_TAG_W-1:0]  old_tag_i,
	input  logic [rob_pkg::ARCH_REG_W-1:0] logic_dest_i,
	input  logic [rob_pkg::XLEN-1:0]       pc_i,
	input  logic                           br_flag_i,
	input  logic                           br_pretaken_i,
	input  logic [rob_pkg::XLEN-1:0]       br_target_i,
	input  logic [rob_pkg::BR_MASK_W-1:0]  br_mask_i,
	input  logic [rob_pkg::FL_HEAD_W-1:0]  fl_head_i,
	input  logic                           store_i,
	input  logic                           halt_i,
	output logic [rob_pkg::ROB_PTR_W-1:0]  tail_idx_o,
	// completion
	input  logic                           complete_valid_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  complete_idx_i,
	// branch resolution
	input  logic                           resolve_valid_i,
	input  logic [rob_pkg::ROB_IDX_W-1:0]  resolve_idx_i,
	input  logic                           resolve_taken_i,
	input  logic [rob_pkg::XLEN-1:0]       resolve_target_i,
	output logic                           recover_o,
	output logic [rob_pkg::FL_HEAD_W-1:0]  recover_fl_head_o,
	output logic [rob_pkg::BR_MASK_W-1:0]  recover_br_mask_o,
	output logic                           br_right_o,
	// retire
	output logic                           retire_valid_o,
	input  logic                           retire_ready_i,
	output logic [rob_pkg::PRF_TAG_W-1:0]  retire_tag_o,
	output logic [rob_pkg::PRF_TAG_W-1:0]  retire_old_tag_o,
	output logic [rob_pkg::ARCH_REG_W-1:0] retire_logic_dest_o,
	output logic                           retire_store_o,
	output logic                           retire_halt_o,
	// npc read
	input  logic [rob_pkg::ROB_IDX_W-1:0]  npc_idx_i,
	output logic [rob_pkg::XLEN-1:0]       npc_o
);

	logic                           dispatch_fire;
	logic                           retire_fire;
	logic                           head_done;
	logic                           mispredict;
	logic [rob_pkg::ROB_IDX_W-1:0]  head_idx;
	logic [rob_pkg::ROB_IDX_W-1:0]  tail_idx;
	logic [rob_pkg::PRF_TAG_W-1:0]  head_new_tag;
	logic [rob_pkg::PRF_TAG_W-1:0]  head_old_tag;
	logic [rob_pkg::ARCH_REG_W-1:0] head_logic_dest;
	logic                           head_store;
	logic                           head_halt;
	logic                           res_br_flag;
	logic                           res_pretaken;
	logic [rob_pkg::XLEN-1:0]       res_target;

	rob_ctrl rob_ctrl_inst (
		.clk              (clk),
		.rst              (rst),
		.dispatch_valid_i (dispatch_valid_i),
		.retire_ready_i   (retire_ready_i),
		.head_done_i      (head_done),
		.recover_req_i    (mispredict),
		.resolve_idx_i    (resolve_idx_i),
		.dispatch_ready_o (dispatch_ready_o),
		.dispatch_fire_o  (dispatch_fire),
		.retire_valid_o   (retire_valid_o),
		.retire_fire_o    (retire_fire),
		.recover_o        (recover_o),
		.head_idx_o       (head_idx),
		.tail_idx_o       (tail_idx),
		.tail_ptr_o       (tail_idx_o)
	);

	rob_entry_store rob_entry_store_inst (
		.clk               (clk),
		.rst               (rst),
		.dispatch_fire_i   (dispatch_fire),
		.tail_idx_i        (tail_idx),
		.head_idx_i        (head_idx),
		.resolve_idx_i     (resolve_idx_i),
		.npc_idx_i         (npc_idx_i),
		.new_tag_i         (new_tag_i),
		.old_tag_i         (old_tag_i),
		.logic_dest_i      (logic_dest_i),
		.pc_i              (pc_i),
		.br_flag_i         (br_flag_i),
		.br_pretaken_i     (br_pretaken_i),
		.br_target_i       (br_target_i),
		.br_mask_i         (br_mask_i),
		.fl_head_i         (fl_head_i),
		.store_i           (store_i),
		.halt_i            (halt_i),
		.head_new_tag_o    (head_new_tag),
		.head_old_tag_o    (head_old_tag),
		.head_logic_dest_o (head_logic_dest),
		.head_store_o      (head_store),
		.head_halt_o       (head_halt),
		.res_br_flag_o     (res_br_flag),
		.res_pretaken_o    (res_pretaken),
		.res_target_o      (res_target),
		.res_fl_head_o     (recover_fl_head_o),
		.res_br_mask_o     (recover_br_mask_o),
		.npc_o             (npc_o)
	);

	rob_done_tracker rob_done_tracker_inst (
		.clk              (clk),
		.rst              (rst),
		.dispatch_fire_i  (dispatch_fire),
		.tail_idx_i       (tail_idx),
		.complete_valid_i (complete_valid_i),
		.complete_idx_i   (complete_idx_i),
		.head_idx_i       (head_idx),
		.head_done_o      (head_done)
	);

	rob_branch_check rob_branch_check_inst (
		.resolve_valid_i  (resolve_valid_i),
		.resolve_taken_i  (resolve_taken_i),
		.resolve_target_i (resolve_target_i),
		.br_flag_i        (res_br_flag),
		.pretaken_i       (res_pretaken),
		.target_i         (res_target),
		.mispredict_o     (mispredict),
		.br_right_o       (br_right_o)
	);

	// ------------------------------
	// retire payload
	// ------------------------------
	assign retire_tag_o = retire_valid_o ? head_new_tag :
		rob_pkg::PRF_TAG_W'(rob_pkg::NULL_TAG);
	assign retire_old_tag_o = retire_valid_o ? head_old_tag :
		rob_pkg::PRF_TAG_W'(rob_pkg::NULL_TAG);
	assign retire_logic_dest_o = retire_valid_o ? head_logic_dest :
		rob_pkg::ARCH_REG_W'(rob_pkg::NULL_TAG);
	assign retire_store_o = retire_valid_o & head_store;   // store queue may commit
	assign retire_halt_o  = retire_valid_o & head_halt;

	// a stalled retire keeps its payload until the consumer takes it
	assert property (@(posedge clk) disable iff (rst)
		retire_valid_o && !retire_fire |=> retire_valid_o &&
		$stable(retire_tag_o) && $stable(retire_old_tag_o) &&
		$stable(retire_logic_dest_o));

endmodule

//--- tb_rob.sv
// trace-driven testbench for the reorder buffer covering retire order, stalls, recovery and npc
`timescale 1ns/100ps

module tb_rob;

	localparam int TIMEOUT = 64;   // cycles allowed for any single wait

	logic clk, rst;
	logic dispatch_valid_i, dispatch_ready_o, br_flag_i, br_pretaken_i, store_i, halt_i;
	logic complete_valid_i, resolve_valid_i, resolve_taken_i, recover_o, br_right_o;
	logic retire_valid_o, retire_ready_i, retire_store_o, retire_halt_o;
	logic [5:0] new_tag_i, old_tag_i, tail_idx_o, retire_tag_o, retire_old_tag_o;
	logic [4:0] logic_dest_i, fl_head_i, complete_idx_i, resolve_idx_i, npc_idx_i;
	logic [4:0] recover_fl_head_o, retire_logic_dest_o;
	logic [3:0] br_mask_i, recover_br_mask_o;
	logic [rob_pkg::XLEN-1:0] pc_i, br_target_i, resolve_target_i, npc_o;

	logic [63:0] fv [12];   // numeric fields of the current trace line
	logic [31:0] rng;
	string       test_name;
	logic        test_bad;
	logic        aborted;
	int          n_tests;
	int          n_fail;

	rob_top rob_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ------------------------------
	// helpers
	// ------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	task automatic report_mismatch(input string what, input logic [63:0] exp,
		input logic [63:0] act);
		$display("FAIL %s %s expected %0h actual %0h", test_name, what, exp, act);
		test_bad = 1'b1;
	endtask

	task automatic close_test();
		n_tests++;
		if (test_bad) begin
			n_fail++;
		end else begin
			$display("PASS %s", test_name);
		end
	endtask

	// rising edge, strobes drop unless the caller drives them again
	task automatic next_cycle();
		@(posedge clk);
		dispatch_valid_i <= 1'b0;
		complete_valid_i <= 1'b0;
		resolve_valid_i  <= 1'b0;
		retire_ready_i   <= 1'b0;
	endtask

	// payload from fv[1..11], returns the index the entry takes
	task automatic send_dispatch(input logic cmp_en, input logic [4:0] cmp_idx,
		output logic [4:0] idx);
		int waited;
		next_cycle();
		dispatch_valid_i <= 1'b1;
		new_tag_i        <= fv[1][5:0];
		old_tag_i        <= fv[2][5:0];
		logic_dest_i     <= fv[3][4:0];
		pc_i             <= fv[4];
		br_flag_i        <= fv[5][0];
		br_pretaken_i    <= fv[6][0];
		br_target_i      <= fv[7];
		br_mask_i        <= fv[8][3:0];
		fl_head_i        <= fv[9][4:0];
		store_i          <= fv[10][0];
		halt_i           <= fv[11][0];
		complete_valid_i <= cmp_en;
		complete_idx_i   <= cmp_idx;
		waited = 0;
		@(negedge clk);
		while (!dispatch_ready_o && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!dispatch_ready_o) begin
			$display("ERROR %s: dispatch_ready_o never went high", test_name);
			test_bad = 1'b1;
			aborted  = 1'b1;
		end
		idx = tail_idx_o[4:0];
	endtask

	// expected payload in fv[0..4], optional random stall before taking it
	task automatic take_retire(input logic hold);
		int          waited;
		logic [18:0] held;
		next_cycle();
		retire_ready_i <= !hold;
		waited = 0;
		@(negedge clk);
		while (!retire_valid_o && waited < TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!retire_valid_o) begin
			$display("ERROR %s: retire_valid_o never went high", test_name);
			test_bad = 1'b1;
			aborted  = 1'b1;
			return;
		end
		if (hold) begin
			held = {retire_tag_o, retire_old_tag_o, retire_logic_dest_o, retire_store_o,
				retire_halt_o};
			rng = xorshift(rng);
			repeat (rng[1:0] + 2) begin
				@(negedge clk);
				if (!retire_valid_o || held !== {retire_tag_o, retire_old_tag_o,
					retire_logic_dest_o, retire_store_o, retire_halt_o}) begin
					$display("ERROR %s: retire output changed while stalled", test_name);
					test_bad = 1'b1;
				end
			end
			@(posedge clk);
			retire_ready_i <= 1'b1;   // handshake lands on the next edge
			@(negedge clk);
		end
		if (retire_tag_o !== fv[0][5:0]) report_mismatch("tag", fv[0], 64'(retire_tag_o));
		if (retire_old_tag_o !== fv[1][5:0])
			report_mismatch("old_tag", fv[1], 64'(retire_old_tag_o));
		if (retire_logic_dest_o !== fv[2][4:0])
			report_mismatch("dest", fv[2], 64'(retire_logic_dest_o));
		if (retire_store_o !== fv[3][0]) report_mismatch("store", fv[3], 64'(retire_store_o));
		if (retire_halt_o !== fv[4][0]) report_mismatch("halt", fv[4], 64'(retire_halt_o));
	endtask

	// fills with generated payloads, each entry completed one cycle after dispatch
	task automatic fill_buffer(input int n, input logic exp_ready);
		logic [4:0] idx;
		logic [4:0] prev;
		prev = '0;
		for (int i = 0; i < n && !aborted; i++) begin
			fv[1]  = 64'(i);
			fv[2]  = 64'(i + rob_pkg::ROB_DEPTH);
			fv[3]  = 64'(i);
			fv[4]  = 64'h4000 + 64'(4 * i);
			fv[5]  = '0;
			fv[6]  = '0;
			fv[7]  = '0;
			fv[8]  = '0;
			fv[9]  = 64'(i);
			fv[10] = '0;
			fv[11] = '0;
			send_dispatch(i > 0, prev, idx);
			prev = idx;
		end
		next_cycle();
		complete_valid_i <= (n > 0);
		complete_idx_i   <= prev;
		@(negedge clk);
		if (dispatch_ready_o !== exp_ready)
			report_mismatch("dispatch_ready_o", 64'(exp_ready), 64'(dispatch_ready_o));
	endtask

	// ------------------------------
	// trace player
	// ------------------------------
	initial begin
		int         fd;
		int         lineno;
		string      line;
		logic [7:0] op;
		logic [4:0] got_idx;
		rst              = 1'b1;
		dispatch_valid_i = 1'b0;
		new_tag_i        = '0;
		old_tag_i        = '0;
		logic_dest_i     = '0;
		pc_i             = '0;
		br_flag_i        = 1'b0;
		br_pretaken_i    = 1'b0;
		br_target_i      = '0;
		br_mask_i        = '0;
		fl_head_i        = '0;
		store_i          = 1'b0;
		halt_i           = 1'b0;
		complete_valid_i = 1'b0;
		complete_idx_i   = '0;
		resolve_valid_i  = 1'b0;
		resolve_idx_i    = '0;
		resolve_taken_i  = 1'b0;
		resolve_target_i = '0;
		retire_ready_i   = 1'b0;
		npc_idx_i        = '0;
		rng      = 32'hf3b8abcc;
		test_bad = 1'b0;
		aborted  = 1'b0;
		n_tests  = 0;
		n_fail   = 0;
		lineno   = 0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		test_name = "reset";
		if (dispatch_ready_o !== 1'b1)
			report_mismatch("dispatch_ready_o", 64'd1, 64'(dispatch_ready_o));
		if ({retire_valid_o, recover_o, br_right_o} !== 3'b000)
			report_mismatch("valid_recover_right", 64'd0,
				64'({retire_valid_o, recover_o, br_right_o}));
		close_test();

		fd = $fopen("rob_trace.txt", "r");
		if (fd == 0) begin
			$display("ERROR could not open rob_trace.txt");
			aborted = 1'b1;
		end
		while (fd != 0 && !aborted && !$feof(fd)) begin
			if ($fgets(line, fd) == 0) break;
			lineno++;
			if (line.len() < 2 || line[0] == "#") continue;
			void'($sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h", op, fv[0], fv[1],
				fv[2], fv[3], fv[4], fv[5], fv[6], fv[7], fv[8], fv[9], fv[10], fv[11]));
			test_name = $sformatf("%c_line%0d", op, lineno);
			test_bad  = 1'b0;
			case (op)
				"D": begin
					send_dispatch(1'b0, 5'd0, got_idx);
					if (got_idx !== fv[0][4:0])
						report_mismatch("tail_idx", fv[0], 64'(got_idx));
					close_test();
				end
				"C": begin
					next_cycle();
					complete_valid_i <= 1'b1;
					complete_idx_i   <= fv[0][4:0];
				end
				"R", "H": begin
					take_retire(op == "H");
					close_test();
				end
				"B": begin
					next_cycle();
					resolve_valid_i  <= 1'b1;
					resolve_idx_i    <= fv[0][4:0];
					resolve_taken_i  <= fv[1][0];
					resolve_target_i <= fv[2];
					@(negedge clk);   // outputs are combinational in this cycle
					if (recover_o !== fv[3][0])
						report_mismatch("recover", fv[3], 64'(recover_o));
					if (br_right_o !== fv[4][0])
						report_mismatch("br_right", fv[4], 64'(br_right_o));
					if (recover_fl_head_o !== fv[5][4:0])
						report_mismatch("fl_head", fv[5], 64'(recover_fl_head_o));
					if (recover_br_mask_o !== fv[6][3:0])
						report_mismatch("br_mask", fv[6], 64'(recover_br_mask_o));
					close_test();
				end
				"N": begin
					next_cycle();
					npc_idx_i <= fv[0][4:0];
					@(negedge clk);
					if (npc_o !== fv[1]) report_mismatch("npc", fv[1], npc_o);
					close_test();
				end
				"F": begin
					fill_buffer(int'(fv[0]), fv[1][0]);
					close_test();
				end
				default: begin
					$display("ERROR line %0d has an unknown op", lineno);
					aborted = 1'b1;
				end
			endcase
		end
		if (fd != 0) $fclose(fd);

		$display("tests %0d passed %0d failed %0d", n_tests, n_tests - n_fail, n_fail);
		if (n_fail == 0 && !aborted) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

//--- rob_trace.txt
# hex fields; D: exp_idx new old dest pc br pretaken target mask fl_head store halt; C: idx
# R/H: new old dest store halt; B: idx taken target recover br_right fl_head mask
# N: idx npc; F: count exp_ready (generated payloads, each completed after dispatch)
D 00 20 01 01 1000 0 0 0 0 03 0 0
D 01 21 02 02 1004 0 0 0 0 04 1 0
D 02 22 03 03 1008 0 0 0 0 05 0 0
C 02
C 00
C 01
R 20 01 01 0 0
H 21 02 02 1 0
R 22 03 03 0 0
N 00 1004
N 01 1008
N 02 100c
# branch at 04 mispredicts on target, second resolve is blocked by the one-shot mark
D 03 23 04 04 2000 0 0 0 0 06 0 0
D 04 24 05 05 2004 1 1 3000 1 07 0 0
D 05 25 06 06 2008 0 0 0 0 08 0 0
D 06 26 07 07 200c 0 0 0 0 09 0 1
C 05
C 06
C 03
B 04 1 3100 1 0 07 1
B 04 0 3000 0 0 07 1
D 05 2a 0b 0b 2100 0 0 0 0 0a 0 0
D 06 2b 0c 0c 2104 1 0 2200 2 0b 0 1
B 06 0 2200 0 1 0b 2
C 04
C 05
C 06
R 23 04 04 0 0
R 24 05 05 0 0
R 2a 0b 0b 0 0
R 2b 0c 0c 0 1
F 20 0
R 00 20 00 0 0
F 0 1

//--- sources.f
rob_pkg.sv
rob_ctrl.sv
rob_entry_store.sv
rob_done_tracker.sv
rob_branch_check.sv
rob_top.sv
tb_rob.sv

//--- Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module tb_rob -f sources.f

sim:
	verilator --binary --timing --assert --top-module tb_rob -f sources.f
	./obj_dir/Vtb_rob > sim.log 2>&1 || echo "CHECKS FAILED (simulator error)" >> sim.log
	cat sim.log
	! grep -q "CHECKS FAILED" sim.log

clean:
	rm -rf obj_dir sim.log
